/* Makefile */
TOP = cpu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		-f compile.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

/* compile.f */
hdl/cpu_pkg.sv
hdl/program_mem.sv
hdl/fetch.sv
hdl/regfile.sv
hdl/decode.sv
hdl/execute.sv
hdl/mem_stage.sv
hdl/cpu_top.sv
verification/cpu_tb.sv

/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   localparam int WORD_W    = 16;
   localparam int PC_W      = 8;
   localparam int DADDR_W   = 8;
   localparam int REG_IDX_W = 4;
   localparam int INSTR_W   = 16;
   localparam int NUM_REGS  = 1 << REG_IDX_W;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [PC_W-1:0]      pc_t;
   typedef logic [DADDR_W-1:0]   daddr_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [INSTR_W-1:0]   instr_t;

   // Bits 15 to 12 of every instruction
   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_OR   = 4'd4,
      OP_XOR  = 4'd5,
      OP_LDI  = 4'd6,
      OP_LD   = 4'd7,
      OP_ST   = 4'd8,
      OP_BEQZ = 4'd9
   } opcode_e;

   typedef struct packed {
      logic   valid;
      pc_t    pc;
      instr_t instr;
   } if_dc_t;

   // LDI immediate in op_b, ST address in op_a and data in op_b
   typedef struct packed {
      logic     valid;
      opcode_e  op;
      reg_idx_t rd;
      word_t    op_a;
      word_t    op_b;
      pc_t      target;
   } dc_ex_t;

   typedef struct packed {
      logic     valid;
      logic     is_load;
      logic     is_store;
      logic     wr_en;
      reg_idx_t rd;
      word_t    result;
      word_t    store_data;
   } ex_mem_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t idx;
      word_t    data;
   } reg_write_t;

   // Load in execute, so the data is not known yet
   typedef struct packed {
      reg_write_t wr;
      logic       is_load;
   } ex_fwd_t;

   typedef struct packed {
      logic taken;
      pc_t  target;
   } redirect_t;

endpackage

`default_nettype wire

/* hdl/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
   parameter int PMEM_DEPTH = 256,
   parameter int DMEM_DEPTH = 256
) (
   input  wire                    clock,
   input  wire                    rst_n,
   input  wire                    prog_we,
   input  wire cpu_pkg::pc_t      prog_addr,
   input  wire cpu_pkg::instr_t   prog_data,
   output cpu_pkg::reg_write_t    retire
);

   import cpu_pkg::*;

   pc_t        pmem_addr;
   instr_t     pmem_instr;
   if_dc_t     if_dc;
   dc_ex_t     dc_ex;
   ex_mem_t    ex_mem;
   ex_fwd_t    ex_fwd;
   reg_write_t mem_fwd;
   redirect_t  redirect;
   logic       stall;
   reg_idx_t   rd_idx_a;
   reg_idx_t   rd_idx_b;
   word_t      rd_data_a;
   word_t      rd_data_b;

   program_mem #(.PMEM_DEPTH(PMEM_DEPTH)) program_mem_inst (
      .clock     (clock),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .addr      (pmem_addr),
      .instr     (pmem_instr)
   );

   fetch fetch_inst (
      .clock      (clock),
      .rst_n      (rst_n),
      .stall      (stall),
      .redirect   (redirect),
      .pmem_addr  (pmem_addr),
      .pmem_instr (pmem_instr),
      .if_dc      (if_dc)
   );

   // Writeback record goes to the register file and out as retire
   regfile regfile_inst (
      .clock     (clock),
      .rst_n     (rst_n),
      .wr        (retire),
      .rd_idx_a  (rd_idx_a),
      .rd_idx_b  (rd_idx_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b)
   );

   decode decode_inst (
      .clock     (clock),
      .rst_n     (rst_n),
      .if_dc     (if_dc),
      .redirect  (redirect),
      .rd_idx_a  (rd_idx_a),
      .rd_idx_b  (rd_idx_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .ex_fwd    (ex_fwd),
      .mem_fwd   (mem_fwd),
      .stall     (stall),
      .dc_ex     (dc_ex)
   );

   execute execute_inst (
      .clock    (clock),
      .rst_n    (rst_n),
      .dc_ex    (dc_ex),
      .ex_fwd   (ex_fwd),
      .redirect (redirect),
      .ex_mem   (ex_mem)
   );

   mem_stage #(.DMEM_DEPTH(DMEM_DEPTH)) mem_stage_inst (
      .clock   (clock),
      .rst_n   (rst_n),
      .ex_mem  (ex_mem),
      .mem_fwd (mem_fwd),
      .wb      (retire)
   );

endmodule

`default_nettype wire

/* hdl/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode (
   input  wire                      clock,
   input  wire                      rst_n,
   input  wire cpu_pkg::if_dc_t     if_dc,
   input  wire cpu_pkg::redirect_t  redirect,
   output cpu_pkg::reg_idx_t        rd_idx_a,
   output cpu_pkg::reg_idx_t        rd_idx_b,
   input  wire cpu_pkg::word_t      rd_data_a,
   input  wire cpu_pkg::word_t      rd_data_b,
   input  wire cpu_pkg::ex_fwd_t    ex_fwd,
   input  wire cpu_pkg::reg_write_t mem_fwd,
   output logic                     stall,
   output cpu_pkg::dc_ex_t          dc_ex
);

   import cpu_pkg::*;

   instr_t   ins;
   opcode_e  op;
   reg_idx_t rd;
   logic     uses_a;
   logic     uses_b;
   logic     load_hit_a;
   logic     load_hit_b;
   word_t    opnd_a;
   word_t    opnd_b;

   logic     valid_q;
   opcode_e  op_q;
   reg_idx_t rd_q;
   word_t    op_a_q;
   word_t    op_b_q;
   pc_t      target_q;

   assign ins = if_dc.instr;
   assign rd  = ins[11:8];

   // Unknown opcodes become NOP
   always_comb begin
      op = OP_NOP;
      if (ins[15:12] <= OP_BEQZ) op = opcode_e'(ins[15:12]);
   end

   always_comb begin
      uses_a = 1'b0;
      uses_b = 1'b0;
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ST: begin
            uses_a = 1'b1;
            uses_b = 1'b1;
         end
         OP_LD, OP_BEQZ: uses_a = 1'b1;
         default: ;
      endcase
   end

   // BEQZ tests the register in the rd field
   assign rd_idx_a = (op == OP_BEQZ) ? rd : ins[7:4];
   assign rd_idx_b = ins[3:0];

   function automatic word_t bypass(reg_idx_t idx, word_t rf_val);
      if (idx == '0) return '0;
      if (ex_fwd.wr.valid && ex_fwd.wr.idx == idx) return ex_fwd.wr.data;
      if (mem_fwd.valid && mem_fwd.idx == idx) return mem_fwd.data;
      return rf_val;
   endfunction

   assign opnd_a = bypass(rd_idx_a, rd_data_a);
   assign opnd_b = (op == OP_LDI) ? word_t'(signed'(ins[7:0])) : bypass(rd_idx_b, rd_data_b);

   // Load result is only there one cycle later
   assign load_hit_a = uses_a && rd_idx_a != '0 && ex_fwd.wr.idx == rd_idx_a;
   assign load_hit_b = uses_b && rd_idx_b != '0 && ex_fwd.wr.idx == rd_idx_b;
   assign stall = if_dc.valid && ex_fwd.wr.valid && ex_fwd.is_load && (load_hit_a || load_hit_b);

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= if_dc.valid && !stall && !redirect.taken;
      end
   end

   always_ff @(posedge clock) begin
      op_q     <= op;
      rd_q     <= rd;
      op_a_q   <= opnd_a;
      op_b_q   <= opnd_b;
      target_q <= ins[7:0];
   end

   assign dc_ex = '{valid: valid_q, op: op_q, rd: rd_q, op_a: op_a_q, op_b: op_b_q,
                    target: target_q};

endmodule

`default_nettype wire

/* hdl/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
   input  wire                  clock,
   input  wire                  rst_n,
   input  wire cpu_pkg::dc_ex_t dc_ex,
   output cpu_pkg::ex_fwd_t     ex_fwd,
   output cpu_pkg::redirect_t   redirect,
   output cpu_pkg::ex_mem_t     ex_mem
);

   import cpu_pkg::*;

   word_t    alu;
   logic     writes_reg;
   logic     wr_en;
   logic     is_load;
   logic     is_store;

   logic     valid_q;
   logic     is_load_q;
   logic     is_store_q;
   logic     wr_en_q;
   reg_idx_t rd_q;
   word_t    result_q;
   word_t    store_data_q;

   // Loads and stores pass the address through
   always_comb begin
      alu        = '0;
      writes_reg = 1'b1;
      case (dc_ex.op)
         OP_ADD:       alu = dc_ex.op_a + dc_ex.op_b;
         OP_SUB:       alu = dc_ex.op_a - dc_ex.op_b;
         OP_AND:       alu = dc_ex.op_a & dc_ex.op_b;
         OP_OR:        alu = dc_ex.op_a | dc_ex.op_b;
         OP_XOR:       alu = dc_ex.op_a ^ dc_ex.op_b;
         OP_LDI:       alu = dc_ex.op_b;
         OP_LD:        alu = dc_ex.op_a;
         OP_ST: begin
            alu        = dc_ex.op_a;
            writes_reg = 1'b0;
         end
         default:      writes_reg = 1'b0;
      endcase
   end

   assign wr_en    = dc_ex.valid && writes_reg && dc_ex.rd != '0;
   assign is_load  = dc_ex.valid && dc_ex.op == OP_LD;
   assign is_store = dc_ex.valid && dc_ex.op == OP_ST;

   assign ex_fwd = '{wr: '{valid: wr_en, idx: dc_ex.rd, data: alu}, is_load: is_load};

   assign redirect.taken  = dc_ex.valid && dc_ex.op == OP_BEQZ && dc_ex.op_a == '0;
   assign redirect.target = dc_ex.target;

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         valid_q    <= 1'b0;
         is_load_q  <= 1'b0;
         is_store_q <= 1'b0;
         wr_en_q    <= 1'b0;
      end else begin
         valid_q    <= dc_ex.valid;
         is_load_q  <= is_load;
         is_store_q <= is_store;
         wr_en_q    <= wr_en;
      end
   end

   always_ff @(posedge clock) begin
      rd_q         <= dc_ex.rd;
      result_q     <= alu;
      store_data_q <= dc_ex.op_b;
   end

   assign ex_mem = '{valid: valid_q, is_load: is_load_q, is_store: is_store_q,
                     wr_en: wr_en_q, rd: rd_q, result: result_q, store_data: store_data_q};

endmodule

`default_nettype wire

/* hdl/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch (
   input  wire                    clock,
   input  wire                    rst_n,
   input  wire                    stall,
   input  wire cpu_pkg::redirect_t redirect,
   output cpu_pkg::pc_t           pmem_addr,
   input  wire cpu_pkg::instr_t   pmem_instr,
   output cpu_pkg::if_dc_t        if_dc
);

   import cpu_pkg::*;

   pc_t    pc;
   logic   valid_q;
   pc_t    pc_q;
   instr_t instr_q;

   assign pmem_addr = pc;

   // Redirect wins over a stall and drops the word being fetched
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         pc      <= '0;
         valid_q <= 1'b0;
      end else if (redirect.taken) begin
         pc      <= redirect.target;
         valid_q <= 1'b0;
      end else if (!stall) begin
         pc      <= pc + 1'b1;
         valid_q <= 1'b1;
      end
   end

   always_ff @(posedge clock) begin
      if (!redirect.taken && !stall) begin
         pc_q    <= pc;
         instr_q <= pmem_instr;
      end
   end

   assign if_dc = '{valid: valid_q, pc: pc_q, instr: instr_q};

endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
   parameter int DMEM_DEPTH = 256
) (
   input  wire                   clock,
   input  wire                   rst_n,
   input  wire cpu_pkg::ex_mem_t ex_mem,
   output cpu_pkg::reg_write_t   mem_fwd,
   output cpu_pkg::reg_write_t   wb
);

   import cpu_pkg::*;

   localparam int AW = (DMEM_DEPTH > 1) ? $clog2(DMEM_DEPTH) : 1;

   word_t         dmem [DMEM_DEPTH];
   daddr_t        daddr;
   logic [AW-1:0] addr;
   word_t         wr_data;
   logic          wb_valid_q;
   reg_idx_t      wb_idx_q;
   word_t         wb_data_q;

   // Address from the low bits of the register value
   assign daddr = ex_mem.result[DADDR_W-1:0];
   assign addr  = AW'(daddr);

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (ex_mem.valid && ex_mem.is_store) begin
         dmem[addr] <= ex_mem.store_data;
      end
   end

   assign wr_data = ex_mem.is_load ? dmem[addr] : ex_mem.result;
   assign mem_fwd = '{valid: ex_mem.valid && ex_mem.wr_en, idx: ex_mem.rd, data: wr_data};

   // Writeback register
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         wb_valid_q <= 1'b0;
      end else begin
         wb_valid_q <= ex_mem.valid && ex_mem.wr_en;
      end
   end

   always_ff @(posedge clock) begin
      wb_idx_q  <= ex_mem.rd;
      wb_data_q <= wr_data;
   end

   assign wb = '{valid: wb_valid_q, idx: wb_idx_q, data: wb_data_q};

endmodule

`default_nettype wire

/* hdl/program_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module program_mem #(
   parameter int PMEM_DEPTH = 256
) (
   input  wire                  clock,
   input  wire                  prog_we,
   input  wire cpu_pkg::pc_t    prog_addr,
   input  wire cpu_pkg::instr_t prog_data,
   input  wire cpu_pkg::pc_t    addr,
   output cpu_pkg::instr_t      instr
);

   import cpu_pkg::*;

   // Depth is a power of two, so truncation wraps the address
   localparam int AW = (PMEM_DEPTH > 1) ? $clog2(PMEM_DEPTH) : 1;

   instr_t mem [PMEM_DEPTH];

   always_ff @(posedge clock) begin
      if (prog_we) begin
         mem[AW'(prog_addr)] <= prog_data;
      end
   end

   assign instr = mem[AW'(addr)];

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
   input  wire                      clock,
   input  wire                      rst_n,
   input  wire cpu_pkg::reg_write_t wr,
   input  wire cpu_pkg::reg_idx_t   rd_idx_a,
   input  wire cpu_pkg::reg_idx_t   rd_idx_b,
   output cpu_pkg::word_t           rd_data_a,
   output cpu_pkg::word_t           rd_data_b
);

   import cpu_pkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.valid && wr.idx != '0) begin
         regs[wr.idx] <= wr.data;
      end
   end

   // r0 is hardwired and a write in this cycle shows up right away
   function automatic word_t read_port(reg_idx_t idx);
      if (idx == '0) return '0;
      if (wr.valid && wr.idx == idx) return wr.data;
      return regs[idx];
   endfunction

   assign rd_data_a = read_port(rd_idx_a);
   assign rd_data_b = read_port(rd_idx_b);

endmodule

`default_nettype wire

/* verification/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

   import cpu_pkg::*;

   localparam int MEM_WORDS = 256;
   localparam int MAX_STEPS = 4096;

   logic       clock;
   logic       rst_n;
   logic       prog_we;
   pc_t        prog_addr;
   instr_t     prog_data;
   reg_write_t retire;

   instr_t     prog [MEM_WORDS];
   string      sect [MEM_WORDS];
   int         prog_len;
   string      cur_sect;
   logic       running;
   integer     seed;

   int         exp_idx_q [$];
   word_t      exp_data_q [$];
   string      exp_name_q [$];
   int         exp_total;
   int         retired;
   int         checks;
   int         errors;

   cpu_top dut0 (
      .clock     (clock),
      .rst_n     (rst_n),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .retire    (retire)
   );

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   function automatic int rand_below(int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic instr_t reg_word(opcode_e op, int rd, int rs1, int rs2);
      return {op, 4'(rd), 4'(rs1), 4'(rs2)};
   endfunction

   function automatic instr_t ldi_word(int rd, int imm);
      return {OP_LDI, 4'(rd), 8'(imm)};
   endfunction

   function automatic instr_t beqz_word(int rs, int target);
      return {OP_BEQZ, 4'(rs), 8'(target)};
   endfunction

   task automatic emit(instr_t word);
      prog[prog_len] = word;
      sect[prog_len] = cur_sect;
      prog_len++;
   endtask

   task automatic build_program();
      int here;
      prog_len = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         prog[i] = '0;
      end

      cur_sect = "alu";
      for (int r = 1; r <= 8; r++) begin
         emit(ldi_word(r, rand_below(256)));
      end
      // Sources include r0 now and then
      for (int i = 0; i < 16; i++) begin
         emit(reg_word(opcode_e'(1 + rand_below(5)), 1 + rand_below(8),
                       rand_below(9), rand_below(9)));
      end

      cur_sect = "forward";
      emit(ldi_word(1, 8'h35));
      emit(reg_word(OP_ADD, 2, 1, 1));
      emit(ldi_word(3, -7));
      emit(reg_word(OP_OR, 9, 1, 0));
      emit(reg_word(OP_XOR, 4, 3, 2));
      emit(ldi_word(5, 100));
      emit(reg_word(OP_AND, 10, 2, 2));
      emit(reg_word(OP_ADD, 11, 4, 1));
      emit(reg_word(OP_SUB, 6, 5, 3));
      emit(reg_word(OP_SUB, 6, 6, 4));

      cur_sect = "load_store";
      emit(ldi_word(7, 8'h20));
      emit(ldi_word(8, -100));
      emit(reg_word(OP_ST, 0, 7, 8));
      emit(reg_word(OP_LD, 9, 7, 0));
      // Load result used by the next instruction
      emit(reg_word(OP_ADD, 10, 9, 8));
      emit(reg_word(OP_ST, 0, 2, 10));
      emit(reg_word(OP_LD, 12, 2, 0));
      emit(reg_word(OP_XOR, 13, 12, 9));

      cur_sect = "branch";
      emit(ldi_word(11, 0));
      here = prog_len;
      emit(beqz_word(11, here + 3));
      emit(ldi_word(12, 8'h11));
      emit(ldi_word(13, 8'h22));
      emit(ldi_word(11, 1));
      here = prog_len;
      emit(beqz_word(11, here + 3));
      emit(ldi_word(12, 8'h33));
      emit(ldi_word(13, 8'h44));
      // Branch on a value that comes straight from a load
      emit(reg_word(OP_LD, 15, 0, 0));
      here = prog_len;
      emit(beqz_word(15, here + 2));
      emit(ldi_word(12, 8'h55));
      emit(reg_word(OP_ADD, 14, 12, 13));

      cur_sect = "reg_zero";
      emit(ldi_word(0, 8'h7f));
      emit(reg_word(OP_ADD, 0, 1, 3));
      emit(reg_word(OP_OR, 15, 0, 1));
      emit(reg_word(OP_LD, 0, 7, 0));
      emit(reg_word(OP_ADD, 15, 0, 0));

      cur_sect = "end";
      here = prog_len;
      emit(beqz_word(0, here));
   endtask

   // ISA model that stops at the branch to itself
   function automatic void run_model();
      word_t  regs [16];
      word_t  dmem [MEM_WORDS];
      instr_t ins;
      int     pc;
      int     next_pc;
      int     rd;
      word_t  a;
      word_t  b;
      word_t  res;
      logic   wr;
      for (int i = 0; i < 16; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < MEM_WORDS; i++) begin
         dmem[i] = '0;
      end
      pc = 0;
      for (int step = 0; step < MAX_STEPS; step++) begin
         ins     = prog[pc];
         rd      = int'(ins[11:8]);
         a       = regs[ins[7:4]];
         b       = regs[ins[3:0]];
         next_pc = (pc + 1) % MEM_WORDS;
         wr      = 1'b1;
         res     = '0;
         case (ins[15:12])
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_LDI:  res = {{8{ins[7]}}, ins[7:0]};
            OP_LD:   res = dmem[a[7:0]];
            OP_ST: begin
               dmem[a[7:0]] = b;
               wr = 1'b0;
            end
            OP_BEQZ: begin
               wr = 1'b0;
               if (regs[rd] == '0) begin
                  if (int'(ins[7:0]) == pc) return;
                  next_pc = int'(ins[7:0]);
               end
            end
            default: wr = 1'b0;
         endcase
         if (wr && rd != 0) begin
            regs[rd] = res;
            exp_idx_q.push_back(rd);
            exp_data_q.push_back(res);
            exp_name_q.push_back($sformatf("%s pc %0d", sect[pc], pc));
         end
         pc = next_pc;
      end
      errors++;
      $display("Reference model never reached the final loop");
   endfunction

   task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic finish_run();
      if (exp_idx_q.size() != 0) begin
         errors++;
         $display("%0d expected register writes never retired", exp_idx_q.size());
      end
      check("retire count", exp_total, retired);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   endtask

   // Each retired write against the next model entry
   always @(negedge clock) begin
      string name;
      if (!rst_n) begin
         if (retire.valid !== 1'b0) begin
            errors++;
            $display("Retire valid was high while reset was held");
         end
      end else if (retire.valid === 1'b1) begin
         retired++;
         if (exp_idx_q.size() == 0) begin
            errors++;
            $display("Extra retire of r%0d with data %h", retire.idx, retire.data);
         end else begin
            name = exp_name_q.pop_front();
            check({name, " index"}, exp_idx_q.pop_front(), retire.idx);
            check({name, " data"}, exp_data_q.pop_front(), retire.data);
         end
      end
   end

   initial begin
      rst_n     = 1'b1;
      prog_we   = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      seed      = 56;
      errors    = 0;
      checks    = 0;
      retired   = 0;
      running   = 1'b0;
      build_program();
      run_model();
      exp_total = exp_idx_q.size();

      // Reset stays low while the program loads, then 10 cycles more
      @(posedge clock);
      rst_n <= 1'b0;
      for (int i = 0; i < prog_len; i++) begin
         @(posedge clock);
         prog_we   <= 1'b1;
         prog_addr <= pc_t'(i);
         prog_data <= prog[i];
      end
      @(posedge clock);
      prog_we <= 1'b0;
      repeat (10) @(posedge clock);
      rst_n   <= 1'b1;
      running = 1'b1;

      wait (retired >= exp_total);
      // Room for any retire that should not be there
      repeat (40) @(posedge clock);
      finish_run();
   end

   initial begin
      int limit;
      wait (running);
      limit = 20 * prog_len + 100;
      repeat (limit) @(posedge clock);
      errors++;
      $display("Timeout after %0d cycles with %0d of %0d writes retired",
               limit, retired, exp_total);
      finish_run();
   end

endmodule

`default_nettype wire
